// File: hw/io_map_defines.svh
`ifndef IO_MAP_DEFINES_SVH
`define IO_MAP_DEFINES_SVH

// I/O word addresses
`define IO_UART_CTRL        14'd0
`define IO_UART_RX          14'd1
`define IO_UART_TX          14'd2
`define IO_CYCLES           14'd4
`define IO_INSTRET          14'd5
`define IO_CNT_CLEAR        14'd6
`define IO_BTN_EMPTY        14'd8
`define IO_BTN_DATA         14'd9
`define IO_SWITCHES         14'd10
`define IO_LEDS             14'd12

// Carrier words occupy BASE to BASE + NUM_CARRIERS - 1
`define IO_CARRIER_FCW_BASE 14'd64
`define IO_MOD_FCW          14'd128
`define IO_MOD_SHIFT        14'd129
`define IO_NOTE_EN          14'd130
`define IO_TX_REQ           14'd132
`define IO_TX_ACK           14'd133

`define BTN_FIFO_DEPTH      8
`define NUM_CARRIERS        4
`define LED_WIDTH           6

`endif

// File: hw/io_pkg.sv
`default_nettype none

package io_pkg;

    typedef logic [13:0] io_addr_t;
    typedef logic [31:0] io_data_t;
    typedef logic [3:0]  io_be_t;

    typedef logic [2:0]  button_t;
    typedef logic [1:0]  switch_t;
    typedef logic [7:0]  byte_t;

endpackage

`default_nettype wire

// File: hw/synth_pkg.sv
`default_nettype none

package synth_pkg;

    // NCO frequency control word
    typedef logic [23:0] fcw_t;
    typedef logic [4:0]  shift_t;
    typedef logic [3:0]  note_mask_t;

endpackage

`default_nettype wire

// File: hw/sync_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  DEPTH  = 8
) (
    input  wire        clk,
    input  wire        rst,
    input  wire        push,
    input  wire item_t din,
    output logic       full,
    input  wire        pop,
    output item_t      dout,
    output logic       empty
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    item_t           mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            do_push;
    logic            do_pop;

    assign full    = (count == CW'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Show-ahead
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(do_push) - CW'(do_pop);
        end
    end

endmodule

`default_nettype wire

// File: hw/button_capture.sv
`timescale 1ns/1ns
`default_nettype none
`include "io_map_defines.svh"

module button_capture (
    input  wire                   clk,
    input  wire                   rst,
    input  wire io_pkg::button_t  buttons,
    input  wire io_pkg::io_addr_t io_addr,
    input  wire                   io_re,
    output io_pkg::button_t       btn_head,
    output logic                  btn_empty
);
    io_pkg::button_t buttons_q;
    logic            any_rise;
    logic            fifo_full;
    logic            fifo_push;
    logic            fifo_pop;

    always_ff @(posedge clk) begin
        if (rst) begin
            buttons_q <= '0;
        end else begin
            buttons_q <= buttons;
        end
    end

    assign any_rise  = |(buttons & ~buttons_q);
    // Presses arriving while full are lost
    assign fifo_push = any_rise && !fifo_full;
    assign fifo_pop  = io_re && (io_addr == `IO_BTN_DATA);

    sync_fifo #(
        .item_t (io_pkg::button_t),
        .DEPTH  (`BTN_FIFO_DEPTH)
    ) u_btn_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (fifo_push),
        .din   (buttons),
        .full  (fifo_full),
        .pop   (fifo_pop),
        .dout  (btn_head),
        .empty (btn_empty)
    );

endmodule

`default_nettype wire

// File: hw/uart_port_regs.sv
`timescale 1ns/1ns
`default_nettype none
`include "io_map_defines.svh"

module uart_port_regs (
    input  wire                   clk,
    input  wire                   rst,
    input  wire io_pkg::io_addr_t io_addr,
    input  wire io_pkg::io_data_t io_wdata,
    input  wire io_pkg::io_be_t   io_we,
    input  wire                   io_re,
    output io_pkg::byte_t         tx_data,
    output logic                  tx_valid,
    input  wire                   tx_ready,
    output logic                  rx_ready
);
    logic tx_write;
    logic has_byte;

    assign tx_write = (io_addr == `IO_UART_TX) && io_we[0];

    always_ff @(posedge clk) begin
        if (tx_write) begin
            tx_data <= io_wdata[7:0];
        end
    end

    // Byte stays offered until the UART takes it
    always_ff @(posedge clk) begin
        if (rst) begin
            has_byte <= 1'b0;
        end else if (tx_write) begin
            has_byte <= 1'b1;
        end else if (has_byte && tx_ready) begin
            has_byte <= 1'b0;
        end
    end

    assign tx_valid = has_byte;

    // One-cycle ack after a load of the receive register
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_ready <= 1'b0;
        end else begin
            rx_ready <= io_re && (io_addr == `IO_UART_RX);
        end
    end

endmodule

`default_nettype wire

// File: hw/perf_counters.sv
`timescale 1ns/1ns
`default_nettype none
`include "io_map_defines.svh"

module perf_counters (
    input  wire                   clk,
    input  wire                   rst,
    input  wire io_pkg::io_addr_t io_addr,
    input  wire io_pkg::io_be_t   io_we,
    input  wire                   instr_retired,
    output io_pkg::io_data_t      cycle_count,
    output io_pkg::io_data_t      instret_count
);
    logic clear;

    // Any byte lane written at the clear address
    assign clear = (io_addr == `IO_CNT_CLEAR) && (|io_we);

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            instret_count <= '0;
        end else if (instr_retired) begin
            instret_count <= instret_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/output_ctrl_regs.sv
`timescale 1ns/1ns
`default_nettype none
`include "io_map_defines.svh"

module output_ctrl_regs (
    input  wire                     clk,
    input  wire                     rst,
    input  wire io_pkg::io_addr_t   io_addr,
    input  wire io_pkg::io_data_t   io_wdata,
    input  wire io_pkg::io_be_t     io_we,
    output synth_pkg::fcw_t         carrier_fcw_1,
    output synth_pkg::fcw_t         carrier_fcw_2,
    output synth_pkg::fcw_t         carrier_fcw_3,
    output synth_pkg::fcw_t         carrier_fcw_4,
    output synth_pkg::fcw_t         mod_fcw,
    output synth_pkg::shift_t       mod_shift,
    output synth_pkg::note_mask_t   note_enable,
    output logic                    tx_req,
    output logic [`LED_WIDTH-1:0]   leds
);
    localparam int FCW_BYTES = $bits(synth_pkg::fcw_t) / 8;

    synth_pkg::fcw_t carrier_q [`NUM_CARRIERS];

    // Upper lane of the bus word has no storage
    function automatic synth_pkg::fcw_t merge_fcw(
        input synth_pkg::fcw_t  cur,
        input io_pkg::io_data_t wdata,
        input io_pkg::io_be_t   be
    );
        synth_pkg::fcw_t result;
        result = cur;
        for (int b = 0; b < FCW_BYTES; b++) begin
            if (be[b]) begin
                result[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return result;
    endfunction

    for (genvar c = 0; c < `NUM_CARRIERS; c++) begin : g_carrier
        always_ff @(posedge clk) begin
            if (rst) begin
                carrier_q[c] <= '0;
            end else if (io_addr == `IO_CARRIER_FCW_BASE + 14'(c)) begin
                carrier_q[c] <= merge_fcw(carrier_q[c], io_wdata, io_we);
            end
        end
    end

    assign carrier_fcw_1 = carrier_q[0];
    assign carrier_fcw_2 = carrier_q[1];
    assign carrier_fcw_3 = carrier_q[2];
    assign carrier_fcw_4 = carrier_q[3];

    always_ff @(posedge clk) begin
        if (rst) begin
            mod_fcw     <= '0;
            mod_shift   <= '0;
            note_enable <= '0;
            tx_req      <= 1'b0;
            leds        <= '0;
        end else begin
            if (io_addr == `IO_MOD_FCW) begin
                mod_fcw <= merge_fcw(mod_fcw, io_wdata, io_we);
            end
            // Single-byte registers, lane 0 only
            if (io_we[0]) begin
                case (io_addr)
                    `IO_MOD_SHIFT: mod_shift   <= synth_pkg::shift_t'(io_wdata);
                    `IO_NOTE_EN:   note_enable <= synth_pkg::note_mask_t'(io_wdata);
                    `IO_TX_REQ:    tx_req      <= io_wdata[0];
                    `IO_LEDS:      leds        <= io_wdata[`LED_WIDTH-1:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/io_read_mux.sv
`timescale 1ns/1ns
`default_nettype none
`include "io_map_defines.svh"

module io_read_mux (
    input  wire                     clk,
    input  wire                     rst,
    input  wire io_pkg::io_addr_t   io_addr,
    input  wire                     rx_valid,
    input  wire io_pkg::byte_t      rx_data,
    input  wire                     tx_ready,
    input  wire io_pkg::byte_t      tx_data,
    input  wire io_pkg::io_data_t   cycle_count,
    input  wire io_pkg::io_data_t   instret_count,
    input  wire                     btn_empty,
    input  wire io_pkg::button_t    btn_head,
    input  wire io_pkg::switch_t    switches,
    input  wire [`LED_WIDTH-1:0]    leds,
    input  wire                     tx_ack,
    output io_pkg::io_data_t        io_rdata
);
    io_pkg::io_data_t rdata_next;

    always_comb begin
        case (io_addr)
            `IO_UART_CTRL: rdata_next = 32'({rx_valid, tx_ready});
            `IO_UART_RX:   rdata_next = 32'(rx_data);
            `IO_UART_TX:   rdata_next = 32'(tx_data);
            `IO_CYCLES:    rdata_next = cycle_count;
            `IO_INSTRET:   rdata_next = instret_count;
            `IO_BTN_EMPTY: rdata_next = 32'(btn_empty);
            `IO_BTN_DATA:  rdata_next = 32'(btn_head);
            `IO_SWITCHES:  rdata_next = 32'(switches);
            `IO_LEDS:      rdata_next = 32'(leds);
            `IO_TX_ACK:    rdata_next = 32'(tx_ack);
            // Unmapped words read as zero
            default:       rdata_next = '0;
        endcase
    end

    // Load data lags the address by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            io_rdata <= '0;
        end else begin
            io_rdata <= rdata_next;
        end
    end

endmodule

`default_nettype wire

// File: hw/io_subsystem.sv
`timescale 1ns/1ns
`default_nettype none
`include "io_map_defines.svh"

module io_subsystem (
    input  wire                     clk,
    input  wire                     rst,
    input  wire io_pkg::io_addr_t   io_addr,
    input  wire io_pkg::io_data_t   io_wdata,
    input  wire io_pkg::io_be_t     io_we,
    input  wire                     io_re,
    output io_pkg::io_data_t        io_rdata,
    input  wire                     instr_retired,
    input  wire io_pkg::button_t    buttons,
    input  wire io_pkg::switch_t    switches,
    output io_pkg::byte_t           tx_data,
    output logic                    tx_valid,
    input  wire                     tx_ready,
    input  wire io_pkg::byte_t      rx_data,
    input  wire                     rx_valid,
    output logic                    rx_ready,
    input  wire                     tx_ack,
    output synth_pkg::fcw_t         carrier_fcw_1,
    output synth_pkg::fcw_t         carrier_fcw_2,
    output synth_pkg::fcw_t         carrier_fcw_3,
    output synth_pkg::fcw_t         carrier_fcw_4,
    output synth_pkg::fcw_t         mod_fcw,
    output synth_pkg::shift_t       mod_shift,
    output synth_pkg::note_mask_t   note_enable,
    output logic                    tx_req,
    output logic [`LED_WIDTH-1:0]   leds
);
    io_pkg::button_t  btn_head;
    logic             btn_empty;
    io_pkg::io_data_t cycle_count;
    io_pkg::io_data_t instret_count;

    button_capture u_buttons (
        .clk       (clk),
        .rst       (rst),
        .buttons   (buttons),
        .io_addr   (io_addr),
        .io_re     (io_re),
        .btn_head  (btn_head),
        .btn_empty (btn_empty)
    );

    uart_port_regs u_uart (
        .clk      (clk),
        .rst      (rst),
        .io_addr  (io_addr),
        .io_wdata (io_wdata),
        .io_we    (io_we),
        .io_re    (io_re),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .rx_ready (rx_ready)
    );

    perf_counters u_counters (
        .clk           (clk),
        .rst           (rst),
        .io_addr       (io_addr),
        .io_we         (io_we),
        .instr_retired (instr_retired),
        .cycle_count   (cycle_count),
        .instret_count (instret_count)
    );

    output_ctrl_regs u_out_regs (
        .clk           (clk),
        .rst           (rst),
        .io_addr       (io_addr),
        .io_wdata      (io_wdata),
        .io_we         (io_we),
        .carrier_fcw_1 (carrier_fcw_1),
        .carrier_fcw_2 (carrier_fcw_2),
        .carrier_fcw_3 (carrier_fcw_3),
        .carrier_fcw_4 (carrier_fcw_4),
        .mod_fcw       (mod_fcw),
        .mod_shift     (mod_shift),
        .note_enable   (note_enable),
        .tx_req        (tx_req),
        .leds          (leds)
    );

    io_read_mux u_read_mux (
        .clk           (clk),
        .rst           (rst),
        .io_addr       (io_addr),
        .rx_valid      (rx_valid),
        .rx_data       (rx_data),
        .tx_ready      (tx_ready),
        .tx_data       (tx_data),
        .cycle_count   (cycle_count),
        .instret_count (instret_count),
        .btn_empty     (btn_empty),
        .btn_head      (btn_head),
        .switches      (switches),
        .leds          (leds),
        .tx_ack        (tx_ack),
        .io_rdata      (io_rdata)
    );

endmodule

`default_nettype wire

// File: sim/tb_io_subsystem.sv
`timescale 1ns/1ns
`default_nettype none
`include "io_map_defines.svh"

module tb_io_subsystem;

    logic                   clk;
    logic                   rst;
    io_pkg::io_addr_t       io_addr;
    io_pkg::io_data_t       io_wdata;
    io_pkg::io_be_t         io_we;
    logic                   io_re;
    io_pkg::io_data_t       io_rdata;
    logic                   instr_retired;
    io_pkg::button_t        buttons;
    io_pkg::switch_t        switches;
    io_pkg::byte_t          tx_data;
    logic                   tx_valid;
    logic                   tx_ready;
    io_pkg::byte_t          rx_data;
    logic                   rx_valid;
    logic                   rx_ready;
    logic                   tx_ack;
    synth_pkg::fcw_t        carrier_fcw_1;
    synth_pkg::fcw_t        carrier_fcw_2;
    synth_pkg::fcw_t        carrier_fcw_3;
    synth_pkg::fcw_t        carrier_fcw_4;
    synth_pkg::fcw_t        mod_fcw;
    synth_pkg::shift_t      mod_shift;
    synth_pkg::note_mask_t  note_enable;
    logic                   tx_req;
    logic [`LED_WIDTH-1:0]  leds;

    // Reference model state
    synth_pkg::fcw_t        m_carrier [`NUM_CARRIERS];
    synth_pkg::fcw_t        m_mod_fcw;
    synth_pkg::shift_t      m_shift;
    synth_pkg::note_mask_t  m_note;
    logic                   m_tx_req;
    logic [`LED_WIDTH-1:0]  m_leds;
    io_pkg::byte_t          m_tx_data;
    logic                   m_tx_known;
    logic                   m_tx_valid;
    logic                   m_rx_ready;
    io_pkg::io_data_t       m_cycles;
    io_pkg::io_data_t       m_instret;
    io_pkg::button_t        m_btn_q [$];
    io_pkg::button_t        m_btn_prev;
    io_pkg::io_data_t       m_rdata;
    logic                   m_rdata_chk;

    int                     mismatches;
    int                     timeouts;
    logic [31:0]            rng_state;
    io_pkg::button_t        next_buttons;
    logic                   next_tx_ready;

    io_subsystem dut (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] rand32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [31:0] apply_lanes(input logic [31:0] cur, input logic [31:0] wdata,
                                                input logic [3:0] be);
        logic [31:0] r;
        r = cur;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                r[i*8 +: 8] = wdata[i*8 +: 8];
            end
        end
        return r;
    endfunction

    function automatic logic is_mapped(input io_pkg::io_addr_t a);
        case (a)
            `IO_UART_CTRL, `IO_UART_RX, `IO_UART_TX, `IO_CYCLES, `IO_INSTRET,
            `IO_CNT_CLEAR, `IO_BTN_EMPTY, `IO_BTN_DATA, `IO_SWITCHES, `IO_LEDS,
            `IO_MOD_FCW, `IO_MOD_SHIFT, `IO_NOTE_EN, `IO_TX_REQ, `IO_TX_ACK: return 1'b1;
            default: return (a >= `IO_CARRIER_FCW_BASE) &&
                            (a < `IO_CARRIER_FCW_BASE + 14'(`NUM_CARRIERS));
        endcase
    endfunction

    function automatic io_pkg::io_addr_t pick_unmapped();
        logic [31:0] r;
        for (int i = 0; i < 100; i++) begin
            r = rand32();
            if (!is_mapped(r[13:0])) begin
                return r[13:0];
            end
        end
        return 14'd3;
    endfunction

    // Write-only registers have no readback path
    function automatic io_pkg::io_data_t predict_read(input io_pkg::io_addr_t a);
        case (a)
            `IO_UART_CTRL: return {30'b0, rx_valid, tx_ready};
            `IO_UART_RX:   return 32'(rx_data);
            `IO_UART_TX:   return 32'(m_tx_data);
            `IO_CYCLES:    return m_cycles;
            `IO_INSTRET:   return m_instret;
            `IO_BTN_EMPTY: return 32'(m_btn_q.size() == 0);
            `IO_BTN_DATA:  return (m_btn_q.size() > 0) ? 32'(m_btn_q[0]) : 32'b0;
            `IO_SWITCHES:  return 32'(switches);
            `IO_LEDS:      return 32'(m_leds);
            `IO_TX_ACK:    return 32'(tx_ack);
            default:       return 32'b0;
        endcase
    endfunction

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    always @(posedge clk) begin : model_update
        int depth_before;
        logic rose;
        m_rdata = predict_read(io_addr);
        m_rdata_chk = !((io_addr == `IO_UART_TX && !m_tx_known) ||
                        (io_addr == `IO_BTN_DATA && m_btn_q.size() == 0));
        if (rst) begin
            m_rdata = '0;
            foreach (m_carrier[c]) begin
                m_carrier[c] = '0;
            end
            m_mod_fcw = '0;
            m_shift = '0;
            m_note = '0;
            m_tx_req = 1'b0;
            m_leds = '0;
            m_tx_known = 1'b0;
            m_tx_valid = 1'b0;
            m_rx_ready = 1'b0;
            m_cycles = '0;
            m_instret = '0;
            m_btn_q.delete();
            m_btn_prev = '0;
        end else begin
            if (io_we != 4'b0 && io_addr == `IO_CNT_CLEAR) begin
                m_cycles = '0;
                m_instret = '0;
            end else begin
                m_cycles++;
                if (instr_retired) begin
                    m_instret++;
                end
            end
            for (int c = 0; c < `NUM_CARRIERS; c++) begin
                if (io_addr == `IO_CARRIER_FCW_BASE + 14'(c)) begin
                    m_carrier[c] = 24'(apply_lanes(32'(m_carrier[c]), io_wdata, io_we));
                end
            end
            if (io_addr == `IO_MOD_FCW) begin
                m_mod_fcw = 24'(apply_lanes(32'(m_mod_fcw), io_wdata, io_we));
            end
            if (io_we[0]) begin
                case (io_addr)
                    `IO_MOD_SHIFT: m_shift = io_wdata[4:0];
                    `IO_NOTE_EN:   m_note = io_wdata[3:0];
                    `IO_TX_REQ:    m_tx_req = io_wdata[0];
                    `IO_LEDS:      m_leds = io_wdata[`LED_WIDTH-1:0];
                    default: ;
                endcase
            end
            if (io_we[0] && io_addr == `IO_UART_TX) begin
                m_tx_data = io_wdata[7:0];
                m_tx_known = 1'b1;
                m_tx_valid = 1'b1;
            end else if (m_tx_valid && tx_ready) begin
                m_tx_valid = 1'b0;
            end
            m_rx_ready = io_re && (io_addr == `IO_UART_RX);
            // Full and empty are judged before this edge's push and pop
            depth_before = m_btn_q.size();
            rose = |(buttons & ~m_btn_prev);
            if (io_re && io_addr == `IO_BTN_DATA && depth_before > 0) begin
                void'(m_btn_q.pop_front());
            end
            if (rose && depth_before < `BTN_FIFO_DEPTH) begin
                m_btn_q.push_back(buttons);
            end
            m_btn_prev = buttons;
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (m_rdata_chk) begin
                check_hex("io_rdata", io_rdata, m_rdata);
            end
            check_hex("carrier_fcw_1", 32'(carrier_fcw_1), 32'(m_carrier[0]));
            check_hex("carrier_fcw_2", 32'(carrier_fcw_2), 32'(m_carrier[1]));
            check_hex("carrier_fcw_3", 32'(carrier_fcw_3), 32'(m_carrier[2]));
            check_hex("carrier_fcw_4", 32'(carrier_fcw_4), 32'(m_carrier[3]));
            check_hex("mod_fcw", 32'(mod_fcw), 32'(m_mod_fcw));
            check_hex("mod_shift", 32'(mod_shift), 32'(m_shift));
            check_hex("note_enable", 32'(note_enable), 32'(m_note));
            check_hex("tx_req", 32'(tx_req), 32'(m_tx_req));
            check_hex("leds", 32'(leds), 32'(m_leds));
            check_hex("tx_valid", 32'(tx_valid), 32'(m_tx_valid));
            check_hex("rx_ready", 32'(rx_ready), 32'(m_rx_ready));
            if (m_tx_valid) begin
                check_hex("tx_data", 32'(tx_data), 32'(m_tx_data));
            end
        end
    end

    // One bus cycle, applied on the rising edge
    task automatic step(input io_pkg::io_addr_t a, input io_pkg::io_data_t d,
                        input io_pkg::io_be_t we, input logic re);
        logic [31:0] r;
        @(posedge clk);
        r = rand32();
        io_addr <= a;
        io_wdata <= d;
        io_we <= we;
        io_re <= re;
        instr_retired <= r[0];
        rx_valid <= r[1];
        rx_data <= r[15:8];
        switches <= r[17:16];
        tx_ack <= r[18];
        buttons <= next_buttons;
        tx_ready <= next_tx_ready;
    endtask

    task automatic idle();
        step(`IO_UART_CTRL, 32'b0, 4'b0, 1'b0);
    endtask

    initial begin : stimulus
        io_pkg::io_addr_t writable [9];
        logic [31:0] r;
        int n;
        writable = '{14'd64, 14'd65, 14'd66, 14'd67, `IO_MOD_FCW, `IO_MOD_SHIFT,
                     `IO_NOTE_EN, `IO_TX_REQ, `IO_LEDS};
        rng_state = 32'h24f4_46c3;
        mismatches = 0;
        timeouts = 0;
        rst = 1'b1;
        io_addr = '0;
        io_wdata = '0;
        io_we = '0;
        io_re = 1'b0;
        instr_retired = 1'b0;
        buttons = '0;
        switches = '0;
        tx_ready = 1'b0;
        rx_data = '0;
        rx_valid = 1'b0;
        tx_ack = 1'b0;
        next_buttons = '0;
        next_tx_ready = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Register writes, with unmapped writes and reads mixed in
        repeat (80) begin
            r = rand32();
            if (r[1:0] == 2'b00) begin
                step(pick_unmapped(), rand32(), r[7:4], r[8]);
            end else begin
                step(writable[r[12:9] % 9], rand32(), r[7:4], 1'b0);
            end
        end
        repeat (10) begin
            step(pick_unmapped(), 32'b0, 4'b0, 1'b1);
            step(`IO_LEDS, 32'b0, 4'b0, 1'b1);
        end

        // Transmit holding register under back-pressure
        repeat (4) begin
            next_tx_ready = 1'b0;
            idle();
            step(`IO_UART_TX, rand32(), 4'b0001, 1'b0);
            repeat (2 + int'(rand32() % 6)) begin
                idle();
            end
            step(`IO_UART_TX, 32'b0, 4'b0, 1'b1);
            next_tx_ready = 1'b1;
            idle();
            @(negedge clk);
            n = 0;
            while (tx_valid && n < 10) begin
                idle();
                @(negedge clk);
                n++;
            end
            if (tx_valid) begin
                timeouts++;
                $display("Timeout: tx_valid did not fall after tx_ready was raised");
            end
        end
        next_tx_ready = 1'b0;

        // Receive loads and their acknowledge pulses
        repeat (12) begin
            r = rand32();
            step(r[0] ? `IO_UART_RX : `IO_UART_CTRL, 32'b0, 4'b0, 1'b1);
            repeat (int'(r[2:1])) begin
                idle();
            end
        end

        // Counter clear and readback
        repeat (3) begin
            r = rand32();
            step(`IO_CNT_CLEAR, rand32(), r[3:0] | 4'b0001, 1'b0);
            repeat (5 + int'(r[7:4])) begin
                idle();
            end
            step(`IO_CYCLES, 32'b0, 4'b0, 1'b1);
            step(`IO_INSTRET, 32'b0, 4'b0, 1'b1);
        end

        // Button bursts overflow the FIFO, then random presses with pops
        for (int i = 0; i < 24; i++) begin
            r = rand32();
            next_buttons = i[0] ? 3'b000 : (r[2:0] | 3'b001);
            step(`IO_BTN_EMPTY, 32'b0, 4'b0, 1'b1);
        end
        repeat (30) begin
            r = rand32();
            next_buttons = r[2:0];
            step(r[4:3] == 2'b00 ? `IO_BTN_DATA : `IO_BTN_EMPTY, 32'b0, 4'b0, 1'b1);
        end
        next_buttons = '0;
        idle();
        n = 0;
        step(`IO_BTN_EMPTY, 32'b0, 4'b0, 1'b1);
        idle();
        @(negedge clk);
        while (io_rdata[0] !== 1'b1 && n < 16) begin
            step(`IO_BTN_DATA, 32'b0, 4'b0, 1'b1);
            step(`IO_BTN_EMPTY, 32'b0, 4'b0, 1'b1);
            idle();
            @(negedge clk);
            n++;
        end
        if (io_rdata[0] !== 1'b1) begin
            timeouts++;
            $display("Timeout: button FIFO did not drain");
        end

        // Switch and acknowledge readback
        repeat (20) begin
            r = rand32();
            step(r[0] ? `IO_SWITCHES : `IO_TX_ACK, 32'b0, 4'b0, r[1]);
        end
        repeat (3) begin
            idle();
        end
        @(posedge clk);

        $display("Checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hw
hw/io_pkg.sv
hw/synth_pkg.sv
hw/sync_fifo.sv
hw/button_capture.sv
hw/uart_port_regs.sv
hw/perf_counters.sv
hw/output_ctrl_regs.sv
hw/io_read_mux.sv
hw/io_subsystem.sv
sim/tb_io_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the I/O subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f verilog.f --top-module tb_io_subsystem \
    -Mdir obj_dir -o tb_io_subsystem
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_io_subsystem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0
